// ==== fmul_fmt_pkg.sv ====
// binary64 field widths, field types and fixed encodings
// shared by every pipeline stage of the multiplier
package fmul_fmt_pkg;

  // field widths
  localparam int EXP_W     = 11;
  localparam int FRAC_W    = 52;
  localparam int MANT_W    = FRAC_W + 1;
  localparam int WORD_W    = 1 + EXP_W + FRAC_W;
  localparam int PROD_W    = 2 * MANT_W;
  // two extra bits hold the sign and the carry past EXP_MAX
  localparam int EXP_SUM_W = EXP_W + 2;

  // exponent constants
  localparam int EXP_BIAS = 1023;
  localparam int EXP_MAX  = 2047;

  // packed operand or result word
  typedef logic [WORD_W-1:0] fp_word_t;

  // individual fields
  typedef logic [EXP_W-1:0]  exp_t;
  typedef logic [FRAC_W-1:0] frac_t;
  typedef logic [MANT_W-1:0] mant_t;

  // full mantissa product
  typedef logic [PROD_W-1:0] prod_t;

  // intermediate exponent, may go below zero or past EXP_MAX
  typedef logic signed [EXP_SUM_W-1:0] exp_sum_t;

  // canonical quiet NaN, positive sign
  localparam fp_word_t QNAN_WORD = 64'h7FF8_0000_0000_0000;

  // largest finite magnitude, sign bit clear
  localparam fp_word_t MAX_FINITE_MAG = {1'b0, exp_t'(EXP_MAX - 1), {FRAC_W{1'b1}}};

  // infinity magnitude, sign bit clear
  localparam fp_word_t INF_MAG = {1'b0, exp_t'(EXP_MAX), frac_t'(0)};

endpackage

// ==== fmul_ctrl_pkg.sv ====
// rounding-mode encoding and exception flag layout
// used by the stages that take the mode or raise flags
package fmul_ctrl_pkg;

  // rounding modes
  typedef enum logic [1:0] {
    RND_NEAREST_EVEN = 2'd0,
    RND_ZERO         = 2'd1,
    RND_PLUS         = 2'd2,
    RND_MINUS        = 2'd3
  } rnd_mode_e;

  localparam int FLAG_W = 4;

  // exception flag vector
  typedef logic [FLAG_W-1:0] fp_flags_t;

  // bit positions inside fp_flags_t
  localparam int FLAG_INVALID   = 0;
  localparam int FLAG_OVERFLOW  = 1;
  localparam int FLAG_UNDERFLOW = 2;
  localparam int FLAG_INEXACT   = 3;

endpackage

// ==== fmul_unpack.sv ====
// first multiplier stage: splits and classifies both operands
// registers sign, exponent sum, mantissas and the special class
`timescale 1ns/100ps

module fmul_unpack
  import fmul_fmt_pkg::*;
  import fmul_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  fp_word_t  a,
  input  fp_word_t  b,
  input  rnd_mode_e rnd_mode,
  output logic      s1_valid,
  output logic      s1_sign,
  output exp_sum_t  s1_exp_sum,
  output mant_t     s1_mant_a,
  output mant_t     s1_mant_b,
  output rnd_mode_e s1_rnd_mode,
  output logic      s1_is_nan,
  output logic      s1_is_inf,
  output logic      s1_is_zero
);

  exp_t  exp_a, exp_b;
  frac_t frac_a, frac_b;
  logic  a_zero, a_inf, a_nan;
  logic  b_zero, b_inf, b_nan;
  logic  spec_nan, spec_inf, spec_zero;

  assign exp_a  = a[WORD_W-2 -: EXP_W];
  assign exp_b  = b[WORD_W-2 -: EXP_W];
  assign frac_a = a[FRAC_W-1:0];
  assign frac_b = b[FRAC_W-1:0];

  // denormals land here too and are flushed
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);
  assign a_inf  = (exp_a == exp_t'(EXP_MAX)) && (frac_a == '0);
  assign b_inf  = (exp_b == exp_t'(EXP_MAX)) && (frac_b == '0);
  assign a_nan  = (exp_a == exp_t'(EXP_MAX)) && (frac_a != '0);
  assign b_nan  = (exp_b == exp_t'(EXP_MAX)) && (frac_b != '0);

  // nan first, then infinity, then zero
  assign spec_nan  = a_nan | b_nan | (a_inf & b_zero) | (b_inf & a_zero);
  assign spec_inf  = ~spec_nan & (a_inf | b_inf);
  assign spec_zero = ~spec_nan & ~spec_inf & (a_zero | b_zero);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload only moves with a valid operation
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_sign     <= a[WORD_W-1] ^ b[WORD_W-1];
      s1_exp_sum  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                     - exp_sum_t'(EXP_BIAS);
      s1_mant_a   <= {1'b1, frac_a};
      s1_mant_b   <= {1'b1, frac_b};
      s1_rnd_mode <= rnd_mode;
      s1_is_nan   <= spec_nan;
      s1_is_inf   <= spec_inf;
      s1_is_zero  <= spec_zero;
    end
  end

  // an unknown mode would pick an arbitrary rounding three cycles later
  a_rnd_mode_known: assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |-> !$isunknown(rnd_mode)
  );

endmodule

// ==== fmul_mant_mult.sv ====
// second multiplier stage: registered 53x53 mantissa product
// side information is delayed one cycle to stay aligned
`timescale 1ns/100ps

module fmul_mant_mult
  import fmul_fmt_pkg::*;
  import fmul_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      s1_valid,
  input  logic      s1_sign,
  input  exp_sum_t  s1_exp_sum,
  input  mant_t     s1_mant_a,
  input  mant_t     s1_mant_b,
  input  rnd_mode_e s1_rnd_mode,
  input  logic      s1_is_nan,
  input  logic      s1_is_inf,
  input  logic      s1_is_zero,
  output logic      s2_valid,
  output logic      s2_sign,
  output exp_sum_t  s2_exp_sum,
  output prod_t     s2_prod,
  output rnd_mode_e s2_rnd_mode,
  output logic      s2_is_nan,
  output logic      s2_is_inf,
  output logic      s2_is_zero
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  // the multiplier array is the critical path of the whole unit
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_prod     <= prod_t'(s1_mant_a) * prod_t'(s1_mant_b);
      s2_sign     <= s1_sign;
      s2_exp_sum  <= s1_exp_sum;
      s2_rnd_mode <= s1_rnd_mode;
      s2_is_nan   <= s1_is_nan;
      s2_is_inf   <= s1_is_inf;
      s2_is_zero  <= s1_is_zero;
    end
  end

endmodule

// ==== fmul_round.sv ====
// third multiplier stage: normalize, round, range check and flags
// special classes from the first stage override the rounded result
`timescale 1ns/100ps

module fmul_round
  import fmul_fmt_pkg::*;
  import fmul_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      s2_valid,
  input  logic      s2_sign,
  input  exp_sum_t  s2_exp_sum,
  input  prod_t     s2_prod,
  input  rnd_mode_e s2_rnd_mode,
  input  logic      s2_is_nan,
  input  logic      s2_is_inf,
  input  logic      s2_is_zero,
  output logic      out_valid,
  output fp_word_t  result,
  output fp_flags_t flags
);

  // guard position when the top product bit is set
  localparam int G_HI = PROD_W - 2 - FRAC_W;

  logic          prod_top;
  frac_t         frac_n;
  logic          guard, sticky;
  exp_sum_t      exp_n;
  logic          rnd_inc;
  logic [FRAC_W:0] frac_sum;
  exp_sum_t      exp_r;
  logic          ovf, unf;
  logic          ovf_to_inf;
  fp_word_t      res_d;
  fp_flags_t     flags_d;

  // product lies in [1,4), the top bit picks the shift
  assign prod_top = s2_prod[PROD_W-1];

  always_comb begin
    if (prod_top) begin
      frac_n = s2_prod[PROD_W-2 -: FRAC_W];
      guard  = s2_prod[G_HI];
      sticky = |s2_prod[G_HI-1:0];
    end else begin
      frac_n = s2_prod[PROD_W-3 -: FRAC_W];
      guard  = s2_prod[G_HI-1];
      sticky = |s2_prod[G_HI-2:0];
    end
    exp_n = s2_exp_sum + exp_sum_t'(prod_top);
  end

  always_comb begin
    rnd_inc = 1'b0;
    case (s2_rnd_mode)
      RND_NEAREST_EVEN: rnd_inc = guard & (sticky | frac_n[0]);
      RND_ZERO:         rnd_inc = 1'b0;
      RND_PLUS:         rnd_inc = ~s2_sign & (guard | sticky);
      RND_MINUS:        rnd_inc = s2_sign & (guard | sticky);
    endcase
  end

  // carry out leaves an all-zero fraction and bumps the exponent
  assign frac_sum = {1'b0, frac_n} + (FRAC_W + 1)'(rnd_inc);
  assign exp_r    = exp_n + exp_sum_t'(frac_sum[FRAC_W]);

  assign ovf = (exp_r >= exp_sum_t'(EXP_MAX));
  assign unf = (exp_r <= exp_sum_t'(0));

  // directed modes clip to max finite on the side they round away from
  always_comb begin
    case (s2_rnd_mode)
      RND_NEAREST_EVEN: ovf_to_inf = 1'b1;
      RND_ZERO:         ovf_to_inf = 1'b0;
      RND_PLUS:         ovf_to_inf = ~s2_sign;
      default:          ovf_to_inf = s2_sign;
    endcase
  end

  always_comb begin
    flags_d = '0;
    if (s2_is_nan) begin
      res_d                 = QNAN_WORD;
      flags_d[FLAG_INVALID] = 1'b1;
    end else if (s2_is_inf) begin
      res_d = {s2_sign, INF_MAG[WORD_W-2:0]};
    end else if (s2_is_zero) begin
      res_d = {s2_sign, {(WORD_W-1){1'b0}}};
    end else begin
      if (ovf) begin
        res_d = ovf_to_inf ? {s2_sign, INF_MAG[WORD_W-2:0]}
                           : {s2_sign, MAX_FINITE_MAG[WORD_W-2:0]};
      end else if (unf) begin
        res_d = {s2_sign, {(WORD_W-1){1'b0}}};
      end else begin
        res_d = {s2_sign, exp_r[EXP_W-1:0], frac_sum[FRAC_W-1:0]};
      end
      flags_d[FLAG_OVERFLOW]  = ovf;
      flags_d[FLAG_UNDERFLOW] = unf;
      flags_d[FLAG_INEXACT]   = guard | sticky | ovf | unf;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      result <= res_d;
      flags  <= flags_d;
    end
  end

  a_out_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
  );

  // nan class is set two stages back, the flag must travel with it
  a_qnan_has_invalid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && result == QNAN_WORD) |-> flags[FLAG_INVALID]
  );

endmodule

// ==== fmul_top.sv ====
// binary64 multiplier top: unpack, mantissa product, round
// one operation per cycle, result three stages after the input sample
`timescale 1ns/100ps

module fmul_top
  import fmul_fmt_pkg::*;
  import fmul_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  fp_word_t  a,
  input  fp_word_t  b,
  input  rnd_mode_e rnd_mode,
  output logic      out_valid,
  output fp_word_t  result,
  output fp_flags_t flags
);

  // unpack to mantissa multiplier
  logic      s1_valid, s1_sign;
  exp_sum_t  s1_exp_sum;
  mant_t     s1_mant_a, s1_mant_b;
  rnd_mode_e s1_rnd_mode;
  logic      s1_is_nan, s1_is_inf, s1_is_zero;

  // mantissa multiplier to rounder
  logic      s2_valid, s2_sign;
  exp_sum_t  s2_exp_sum;
  prod_t     s2_prod;
  rnd_mode_e s2_rnd_mode;
  logic      s2_is_nan, s2_is_inf, s2_is_zero;

  fmul_unpack u_unpack (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .rnd_mode(rnd_mode),
    .s1_valid(s1_valid), .s1_sign(s1_sign), .s1_exp_sum(s1_exp_sum),
    .s1_mant_a(s1_mant_a), .s1_mant_b(s1_mant_b), .s1_rnd_mode(s1_rnd_mode),
    .s1_is_nan(s1_is_nan), .s1_is_inf(s1_is_inf), .s1_is_zero(s1_is_zero)
  );

  fmul_mant_mult u_mant_mult (
    .clk(clk), .rst_n(rst_n),
    .s1_valid(s1_valid), .s1_sign(s1_sign), .s1_exp_sum(s1_exp_sum),
    .s1_mant_a(s1_mant_a), .s1_mant_b(s1_mant_b), .s1_rnd_mode(s1_rnd_mode),
    .s1_is_nan(s1_is_nan), .s1_is_inf(s1_is_inf), .s1_is_zero(s1_is_zero),
    .s2_valid(s2_valid), .s2_sign(s2_sign), .s2_exp_sum(s2_exp_sum),
    .s2_prod(s2_prod), .s2_rnd_mode(s2_rnd_mode),
    .s2_is_nan(s2_is_nan), .s2_is_inf(s2_is_inf), .s2_is_zero(s2_is_zero)
  );

  fmul_round u_round (
    .clk(clk), .rst_n(rst_n),
    .s2_valid(s2_valid), .s2_sign(s2_sign), .s2_exp_sum(s2_exp_sum),
    .s2_prod(s2_prod), .s2_rnd_mode(s2_rnd_mode),
    .s2_is_nan(s2_is_nan), .s2_is_inf(s2_is_inf), .s2_is_zero(s2_is_zero),
    .out_valid(out_valid), .result(result), .flags(flags)
  );

endmodule

// ==== tb_fmul.sv ====
// directed testbench for the binary64 pipelined multiplier
// runs fmul_top against a reference model and a queue of expected results
`timescale 1ns/100ps

module tb_fmul
  import fmul_fmt_pkg::*;
  import fmul_ctrl_pkg::*;
;

  localparam int WAIT_LIMIT = 200;
  localparam fp_flags_t NO_FLAGS = '0;
  localparam fp_flags_t INV_ONLY = fp_flags_t'(1 << FLAG_INVALID);

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  fp_word_t  a;
  fp_word_t  b;
  rnd_mode_e rnd_mode;
  logic      out_valid;
  fp_word_t  result;
  fp_flags_t flags;

  fp_word_t    exp_results[$];
  fp_flags_t   exp_flags[$];
  string       exp_tags[$];
  int          errors;
  int          checks;
  logic [15:0] lfsr_state;

  fmul_top u_dut (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .rnd_mode(rnd_mode),
    .out_valid(out_valid), .result(result), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    r = 64'd0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // random sign and fraction with the biased exponent drawn from [exp_lo, exp_hi]
  function automatic fp_word_t rand_operand(input int exp_lo, input int exp_hi);
    logic [63:0] t;
    logic        sgn;
    logic [51:0] frac;
    int          ev;
    t    = take_bits(1);
    sgn  = t[0];
    t    = take_bits(52);
    frac = t[51:0];
    t    = take_bits(12);
    ev   = exp_lo + int'(t[11:0]) % (exp_hi - exp_lo + 1);
    return {sgn, ev[10:0], frac};
  endfunction

  // reference model built from the normalize, round and range rules
  function automatic fp_word_t ref_mul(input fp_word_t x, input fp_word_t y,
                                       input rnd_mode_e m, output fp_flags_t f);
    logic         sgn;
    logic [10:0]  ex;
    logic [10:0]  ey;
    logic [51:0]  fx;
    logic [51:0]  fy;
    logic         x_zero, y_zero, x_inf, y_inf, x_nan, y_nan;
    logic [105:0] p;
    logic [52:0]  fr;
    logic         g, st, up, to_inf;
    int           e;
    sgn    = x[63] ^ y[63];
    ex     = x[62:52];
    ey     = y[62:52];
    fx     = x[51:0];
    fy     = y[51:0];
    x_zero = (ex == 11'd0);
    y_zero = (ey == 11'd0);
    x_inf  = (ex == 11'h7FF) && (fx == 52'd0);
    y_inf  = (ey == 11'h7FF) && (fy == 52'd0);
    x_nan  = (ex == 11'h7FF) && (fx != 52'd0);
    y_nan  = (ey == 11'h7FF) && (fy != 52'd0);
    f = 4'b0000;
    if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero)) begin
      f[FLAG_INVALID] = 1'b1;
      return 64'h7FF8_0000_0000_0000;
    end
    if (x_inf || y_inf) return {sgn, 11'h7FF, 52'd0};
    if (x_zero || y_zero) return {sgn, 63'd0};
    p = {53'd0, 1'b1, fx} * {53'd0, 1'b1, fy};
    e = int'(ex) + int'(ey) - 1023;
    if (p[105]) begin
      fr = {1'b0, p[104:53]};
      g  = p[52];
      st = |p[51:0];
      e  = e + 1;
    end else begin
      fr = {1'b0, p[103:52]};
      g  = p[51];
      st = |p[50:0];
    end
    case (m)
      RND_NEAREST_EVEN: up = g & (st | fr[0]);
      RND_ZERO:         up = 1'b0;
      RND_PLUS:         up = ~sgn & (g | st);
      default:          up = sgn & (g | st);
    endcase
    fr = fr + {52'd0, up};
    if (fr[52]) e = e + 1;
    if (e >= 2047) begin
      to_inf = (m == RND_NEAREST_EVEN) || (m == RND_PLUS && !sgn) || (m == RND_MINUS && sgn);
      f[FLAG_OVERFLOW] = 1'b1;
      f[FLAG_INEXACT]  = 1'b1;
      return to_inf ? {sgn, 11'h7FF, 52'd0} : {sgn, 11'h7FE, {52{1'b1}}};
    end
    if (e <= 0) begin
      f[FLAG_UNDERFLOW] = 1'b1;
      f[FLAG_INEXACT]   = 1'b1;
      return {sgn, 63'd0};
    end
    f[FLAG_INEXACT] = g | st;
    return {sgn, e[10:0], fr[51:0]};
  endfunction

  task automatic check_result(input fp_word_t got, input fp_word_t expv, input string tag);
    checks++;
    if (got !== expv) begin
      errors++;
      $display("FAIL %0t: %s result %h expected %h", $time, tag, got, expv);
    end
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t expv, input string tag);
    checks++;
    if (got !== expv) begin
      errors++;
      $display("FAIL %0t: %s flags %b expected %b", $time, tag, got, expv);
    end
  endtask

  // results must come back in issue order
  always @(negedge clk) begin
    if (rst_n && out_valid === 1'b1) begin
      if (exp_results.size() == 0) begin
        errors++;
        $display("out_valid went high at %0t with no operation outstanding", $time);
      end else begin
        check_result(result, exp_results.pop_front(), exp_tags[0]);
        check_flags(flags, exp_flags.pop_front(), exp_tags.pop_front());
      end
    end
  end

  task automatic issue_expect(input fp_word_t x, input fp_word_t y, input rnd_mode_e m,
                              input fp_word_t er, input fp_flags_t ef);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= x;
    b        <= y;
    rnd_mode <= m;
    exp_results.push_back(er);
    exp_flags.push_back(ef);
    exp_tags.push_back($sformatf("%h * %h mode %0d", x, y, m));
  endtask

  task automatic issue(input fp_word_t x, input fp_word_t y, input rnd_mode_e m);
    fp_word_t  er;
    fp_flags_t ef;
    er = ref_mul(x, y, m, ef);
    issue_expect(x, y, m, er, ef);
  endtask

  task automatic drain();
    int n;
    @(posedge clk);
    in_valid <= 1'b0;
    n = 0;
    while (exp_results.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_results.size() != 0) begin
      errors++;
      $display("timed out waiting for %0d results at %0t", exp_results.size(), $time);
      exp_results.delete();
      exp_flags.delete();
      exp_tags.delete();
    end
  endtask

  task automatic test_reset_latency();
    int cycles;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      errors++;
      $display("FAIL %0t: out_valid is %b after reset, expected 0", $time, out_valid);
    end
    issue_expect(64'h3FF8_0000_0000_0000, 64'h4000_0000_0000_0000, RND_NEAREST_EVEN,
                 64'h4008_0000_0000_0000, NO_FLAGS);
    @(posedge clk);
    in_valid <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (out_valid !== 1'b1 && cycles < WAIT_LIMIT);
    if (out_valid !== 1'b1) begin
      errors++;
      $display("timed out waiting for out_valid after a single operation");
    end else if (cycles != 3) begin
      errors++;
      $display("FAIL %0t: out_valid came %0d cycles after the input sample, expected 3",
               $time, cycles);
    end
    drain();
  endtask

  task automatic test_exact_inexact();
    issue_expect(64'h3FF8_0000_0000_0000, 64'h4000_0000_0000_0000, RND_NEAREST_EVEN,
                 64'h4008_0000_0000_0000, NO_FLAGS);
    issue_expect(64'h4008_0000_0000_0000, 64'h3FE0_0000_0000_0000, RND_NEAREST_EVEN,
                 64'h3FF8_0000_0000_0000, NO_FLAGS);
    for (int i = 0; i < 20; i++) begin
      issue(rand_operand(900, 1150), rand_operand(900, 1150), RND_NEAREST_EVEN);
    end
    drain();
  endtask

  task automatic test_rounding();
    fp_word_t xs[4];
    fp_word_t ys[4];
    // half-lsb ties with an odd lsb and then with an even one
    xs[0] = 64'h3FF0_0000_0000_0001;
    ys[0] = 64'h3FF8_0000_0000_0000;
    xs[1] = 64'h3FF0_0000_0000_0003;
    ys[1] = 64'h3FF8_0000_0000_0000;
    xs[2] = rand_operand(1000, 1040);
    ys[2] = rand_operand(1000, 1040);
    xs[3] = rand_operand(1000, 1040);
    ys[3] = rand_operand(1000, 1040);
    for (int i = 0; i < 4; i++) begin
      for (int m = 0; m < 4; m++) begin
        for (int s = 0; s < 2; s++) begin
          issue({xs[i][63] ^ s[0], xs[i][62:0]}, ys[i], rnd_mode_e'(m[1:0]));
        end
      end
    end
    drain();
  endtask

  task automatic test_range();
    for (int m = 0; m < 4; m++) begin
      for (int s = 0; s < 2; s++) begin
        issue({s[0], 63'h7FE0_0000_0000_0000}, 64'h4010_0000_0000_0000, rnd_mode_e'(m[1:0]));
        issue({s[0], 63'h0010_0000_0000_0000}, 64'h3FD0_0000_0000_0000, rnd_mode_e'(m[1:0]));
        issue({s[0], 63'h7FEF_FFFF_FFFF_FFFF}, 64'h3FF0_0000_0000_0000, rnd_mode_e'(m[1:0]));
      end
    end
    drain();
  endtask

  task automatic test_specials();
    issue_expect(64'h7FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000, RND_NEAREST_EVEN,
                 QNAN_WORD, INV_ONLY);
    issue_expect(64'h4000_0000_0000_0000, 64'hFFF8_0000_0000_0000, RND_ZERO,
                 QNAN_WORD, INV_ONLY);
    issue_expect(64'h7FF0_0000_0000_0000, 64'h8000_0000_0000_0000, RND_PLUS,
                 QNAN_WORD, INV_ONLY);
    issue_expect(64'hFFF0_0000_0000_0000, 64'h4000_0000_0000_0000, RND_MINUS,
                 64'hFFF0_0000_0000_0000, NO_FLAGS);
    issue_expect(64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000, RND_NEAREST_EVEN,
                 64'hFFF0_0000_0000_0000, NO_FLAGS);
    issue_expect(64'h0000_0000_0000_0001, 64'h4008_0000_0000_0000, RND_NEAREST_EVEN,
                 64'h0000_0000_0000_0000, NO_FLAGS);
    issue_expect(64'h8000_0000_0000_0000, 64'h4014_0000_0000_0000, RND_PLUS,
                 64'h8000_0000_0000_0000, NO_FLAGS);
    issue_expect(64'h3FF0_0000_0000_0000, 64'h800F_FFFF_FFFF_FFFF, RND_ZERO,
                 64'h8000_0000_0000_0000, NO_FLAGS);
    drain();
  endtask

  // in_valid stays high so three operations are in flight at once
  task automatic test_streaming();
    logic [63:0] t;
    for (int i = 0; i < 64; i++) begin
      t = take_bits(2);
      issue(rand_operand(500, 1500), rand_operand(500, 1500), rnd_mode_e'(t[1:0]));
    end
    drain();
  endtask

  initial begin
    in_valid   = 1'b0;
    a          = '0;
    b          = '0;
    rnd_mode   = RND_NEAREST_EVEN;
    rst_n      = 1'b0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 16'd26490;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_latency();
    test_exact_inexact();
    test_rounding();
    test_range();
    test_specials();
    test_streaming();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== fmul.f ====
fmul_fmt_pkg.sv
fmul_ctrl_pkg.sv
fmul_unpack.sv
fmul_mant_mult.sv
fmul_round.sv
fmul_top.sv
tb_fmul.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fmul
DUT_TOP   ?= fmul_top
FILELIST  ?= fmul.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
